//--- desc_defines.svh
/*
 * Bit positions and widths shared by the segment descriptor unit.
 * Include this header in any file that slices a descriptor or sizes
 * an address, parameter or selector.
 */
`ifndef DESC_DEFINES_SVH
`define DESC_DEFINES_SVH

// Width of addresses, parameters, offsets and limits.
`define ADDR_W 32

// Full descriptor width, read as two address-width words.
`define DESC_W 64

// Number of host parameter registers.
`define PARAM_NUM 5

// Granularity and present bits of a descriptor.
`define DESC_BIT_G 55
`define DESC_BIT_P 47

// Selector layout; index starts above the TI and RPL bits.
`define SEL_W 16
`define SEL_INDEX_LSB 3

// Raw limit field is 4 + 16 bits.
`define DESC_LIMIT_W 20

`endif

//--- desc_limit_checker.sv
/*
 * Segment offset checker.
 * Each check pulse tests an offset against the present bit and scaled
 * limit of the descriptor picked by check_target. The result is
 * registered and shows one cycle later; a new check is taken every cycle.
 */
`timescale 1ns/10ps
`include "desc_defines.svh"

module desc_limit_checker (
    input  logic                 clk,
    input  logic                 rst_n,

    // Check request.
    input  logic                 check,
    input  logic [`ADDR_W-1:0]   offset,
    input  logic                 check_target,

    // Descriptors and their decoded limits.
    input  logic [`DESC_W-1:0]   glob_descriptor,
    input  logic [`DESC_W-1:0]   glob_descriptor_2,
    input  logic [`ADDR_W-1:0]   glob_desc_limit,
    input  logic [`ADDR_W-1:0]   glob_desc_2_limit,

    output logic                 check_valid,
    output desc_pkg::fault_e     check_fault
);

    import desc_pkg::*;

    logic               seg_present;
    logic [`ADDR_W-1:0] seg_limit;
    fault_e             fault_nxt;

    // Target 0 is descriptor 1, target 1 is descriptor 2.
    assign seg_present = check_target ? glob_descriptor_2[`DESC_BIT_P]
                                      : glob_descriptor[`DESC_BIT_P];
    assign seg_limit   = check_target ? glob_desc_2_limit : glob_desc_limit;

    // Present bit wins over the limit test.
    // An offset equal to the limit is still inside.
    always_comb begin
        if (!seg_present) begin
            fault_nxt = FAULT_NOT_PRESENT;
        end else if (offset > seg_limit) begin
            fault_nxt = FAULT_LIMIT;
        end else begin
            fault_nxt = FAULT_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_valid <= 1'b0;
            check_fault <= FAULT_NONE;
        end else begin
            check_valid <= check;
            // Last result holds between checks.
            if (check) begin
                check_fault <= fault_nxt;
            end
        end
    end

endmodule

//--- desc_pkg.sv
/*
 * Shared types of the segment descriptor unit.
 * Modules name these types with scoped names in their port lists and
 * import the package inside the body when the enum values are needed.
 */
`include "desc_defines.svh"

package desc_pkg;

    // Segment selector as written by the host.
    // Bits 15:3 index the table, bit 2 is TI, bits 1:0 are RPL.
    typedef logic [`SEL_W-1:0] sel_t;

    // Fault code reported by selector loads and offset checks.
    typedef enum logic [1:0] {
        // Load or check completed cleanly.
        FAULT_NONE        = 2'd0,
        // Table entry lies beyond the table limit.
        FAULT_SEL_LIMIT   = 2'd1,
        // Descriptor present bit is clear.
        FAULT_NOT_PRESENT = 2'd2,
        // Offset lies beyond the decoded segment limit.
        FAULT_LIMIT       = 2'd3
    } fault_e;

endpackage

//--- desc_table_reader.sv
/*
 * Descriptor table reader.
 * Takes a selector load while idle, checks the entry against the table
 * limit, then reads the 64-bit descriptor as two words from a memory
 * with one cycle of read latency and strobes it into the chosen
 * descriptor register. A load while busy is dropped.
 */
`timescale 1ns/10ps
`include "desc_defines.svh"

module desc_table_reader (
    input  logic                 clk,
    input  logic                 rst_n,

    // Load request from the host.
    input  logic                 load,
    input  desc_pkg::sel_t       sel,
    input  logic                 target,

    // Table location from parameters 1 and 2.
    input  logic [`ADDR_W-1:0]   table_base,
    input  logic [`ADDR_W-1:0]   table_limit,

    // Memory read port.
    input  logic [`ADDR_W-1:0]   mem_rdata,
    output logic                 mem_rd,
    output logic [`ADDR_W-1:0]   mem_addr,

    // Descriptor register writes.
    output logic                 desc_set,
    output logic                 desc_2_set,
    output logic [`DESC_W-1:0]   desc_value,

    // Load status.
    output logic                 busy,
    output logic                 load_done,
    output desc_pkg::fault_e     load_fault
);

    import desc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_LO,
        ST_RD_HI,
        ST_WRITE
    } state_e;

    state_e             state;
    logic               target_q;
    logic               fault_pend;
    logic [`ADDR_W-1:0] low_word;
    logic [`ADDR_W-1:0] entry_off;
    logic [`ADDR_W-1:0] entry_end;
    logic               take_load;
    logic               bound_fail;

    // Entry byte offset is the index times eight.
    assign entry_off  = `ADDR_W'({sel[`SEL_W-1:`SEL_INDEX_LSB], `SEL_INDEX_LSB'(0)});
    assign entry_end  = entry_off + `ADDR_W'(7);
    assign bound_fail = entry_end > table_limit;

    // Busy also covers the cycle of a bound fault.
    assign busy      = (state != ST_IDLE) || fault_pend;
    assign take_load = load && !busy;

    // Main sequence, one state per cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            target_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_load && !bound_fail) begin
                        state    <= ST_RD_LO;
                        target_q <= target;
                    end
                end
                ST_RD_LO: state <= ST_RD_HI;
                ST_RD_HI: state <= ST_WRITE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Read pulses: low word first, high word four bytes up.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rd   <= 1'b0;
            mem_addr <= '0;
        end else begin
            mem_rd <= 1'b0;
            if (take_load && !bound_fail) begin
                mem_rd   <= 1'b1;
                mem_addr <= table_base + entry_off;
            end else if (state == ST_RD_LO) begin
                mem_rd   <= 1'b1;
                mem_addr <= mem_addr + `ADDR_W'(4);
            end
        end
    end

    // Low word arrives while the high read is out.
    always_ff @(posedge clk) begin
        if (state == ST_RD_HI) begin
            low_word <= mem_rdata;
        end
    end

    // High word is on mem_rdata during the write cycle.
    assign desc_value = {mem_rdata, low_word};
    assign desc_set   = (state == ST_WRITE) && !target_q;
    assign desc_2_set = (state == ST_WRITE) && target_q;

    // Completion status, one cycle after the last step.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_pend <= 1'b0;
            load_done  <= 1'b0;
            load_fault <= FAULT_NONE;
        end else begin
            fault_pend <= take_load && bound_fail;
            load_done  <= fault_pend || (state == ST_WRITE);
            if (fault_pend) begin
                load_fault <= FAULT_SEL_LIMIT;
            end else if (state == ST_WRITE) begin
                load_fault <= FAULT_NONE;
            end
        end
    end

endmodule

//--- flist.f
+incdir+.
desc_pkg.sv
global_regs.sv
desc_table_reader.sv
desc_limit_checker.sv
seg_desc_unit.sv
tb_desc_memory.sv
tb_seg_desc_unit.sv

//--- global_regs.sv
/*
 * Global parameter and descriptor register file.
 * Holds five host-written parameters and two 64-bit descriptors, each
 * loaded by its own set strobe. Base and scaled limit of descriptor 1
 * and the scaled limit of descriptor 2 are decoded combinationally.
 */
`timescale 1ns/10ps
`include "desc_defines.svh"

module global_regs (
    input  logic                 clk,
    input  logic                 rst_n,

    // Host parameter writes.
    input  logic [`PARAM_NUM-1:0] param_set,
    input  logic [`ADDR_W-1:0]   param_value,

    // Descriptor writes from the table reader.
    input  logic                 desc_set,
    input  logic                 desc_2_set,
    input  logic [`DESC_W-1:0]   desc_value,

    output logic [`ADDR_W-1:0]   glob_param_1,
    output logic [`ADDR_W-1:0]   glob_param_2,
    output logic [`ADDR_W-1:0]   glob_param_3,
    output logic [`ADDR_W-1:0]   glob_param_4,
    output logic [`ADDR_W-1:0]   glob_param_5,

    output logic [`DESC_W-1:0]   glob_descriptor,
    output logic [`DESC_W-1:0]   glob_descriptor_2,

    output logic [`ADDR_W-1:0]   glob_desc_base,
    output logic [`ADDR_W-1:0]   glob_desc_limit,
    output logic [`ADDR_W-1:0]   glob_desc_2_limit
);

    // Parameter storage, index 0 is parameter 1.
    logic [`ADDR_W-1:0] param_q [`PARAM_NUM];

    // Scale the raw limit by the G bit.
    // With G set the unit is 4 KiB, so the low 12 bits fill with ones.
    function automatic logic [`ADDR_W-1:0] limit_decode(input logic [`DESC_W-1:0] desc);
        logic [`DESC_LIMIT_W-1:0] raw;
        raw = {desc[51:48], desc[15:0]};
        if (desc[`DESC_BIT_G]) begin
            limit_decode = {raw, 12'hFFF};
        end else begin
            limit_decode = `ADDR_W'(raw);
        end
    endfunction

    // Each strobe bit loads its own register.
    // Several bits high at once all take the same value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PARAM_NUM; i++) begin
                param_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PARAM_NUM; i++) begin
                if (param_set[i]) begin
                    param_q[i] <= param_value;
                end
            end
        end
    end

    assign glob_param_1 = param_q[0];
    assign glob_param_2 = param_q[1];
    assign glob_param_3 = param_q[2];
    assign glob_param_4 = param_q[3];
    assign glob_param_5 = param_q[4];

    // Descriptor register 1, the one whose base is used.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            glob_descriptor <= '0;
        end else if (desc_set) begin
            glob_descriptor <= desc_value;
        end
    end

    // Descriptor register 2, range-checked only.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            glob_descriptor_2 <= '0;
        end else if (desc_2_set) begin
            glob_descriptor_2 <= desc_value;
        end
    end

    // Base is split across the top byte and bits 39:16.
    assign glob_desc_base = {glob_descriptor[63:56], glob_descriptor[39:16]};

    // Granularity-scaled limits.
    assign glob_desc_limit   = limit_decode(glob_descriptor);
    assign glob_desc_2_limit = limit_decode(glob_descriptor_2);

endmodule

//--- seg_desc_unit.sv
/*
 * Segment descriptor unit top level.
 * Joins the register file, the descriptor table reader and the offset
 * checker. The host writes parameters, loads selectors and issues
 * checks; the external memory answers reads one cycle after mem_rd.
 */
`timescale 1ns/10ps
`include "desc_defines.svh"

module seg_desc_unit (
    input  logic                 clk,
    input  logic                 rst_n,

    // Host parameter writes.
    input  logic [`PARAM_NUM-1:0] param_set,
    input  logic [`ADDR_W-1:0]   param_value,

    // Selector loads.
    input  logic                 load,
    input  desc_pkg::sel_t       sel,
    input  logic                 target,

    // External memory.
    input  logic [`ADDR_W-1:0]   mem_rdata,
    output logic                 mem_rd,
    output logic [`ADDR_W-1:0]   mem_addr,

    // Offset checks.
    input  logic                 check,
    input  logic [`ADDR_W-1:0]   offset,
    input  logic                 check_target,

    // Status.
    output logic                 busy,
    output logic                 load_done,
    output desc_pkg::fault_e     load_fault,
    output logic                 check_valid,
    output desc_pkg::fault_e     check_fault,

    // Register views.
    output logic [`ADDR_W-1:0]   glob_param_1,
    output logic [`ADDR_W-1:0]   glob_param_2,
    output logic [`ADDR_W-1:0]   glob_param_3,
    output logic [`ADDR_W-1:0]   glob_param_4,
    output logic [`ADDR_W-1:0]   glob_param_5,
    output logic [`DESC_W-1:0]   glob_descriptor,
    output logic [`DESC_W-1:0]   glob_descriptor_2,
    output logic [`ADDR_W-1:0]   glob_desc_base,
    output logic [`ADDR_W-1:0]   glob_desc_limit
);

    // Reader to register file.
    logic               desc_set;
    logic               desc_2_set;
    logic [`DESC_W-1:0] desc_value;

    // Descriptor 2 limit stays internal, only the checker uses it.
    logic [`ADDR_W-1:0] glob_desc_2_limit;

    global_regs u_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .param_set         (param_set),
        .param_value       (param_value),
        .desc_set          (desc_set),
        .desc_2_set        (desc_2_set),
        .desc_value        (desc_value),
        .glob_param_1      (glob_param_1),
        .glob_param_2      (glob_param_2),
        .glob_param_3      (glob_param_3),
        .glob_param_4      (glob_param_4),
        .glob_param_5      (glob_param_5),
        .glob_descriptor   (glob_descriptor),
        .glob_descriptor_2 (glob_descriptor_2),
        .glob_desc_base    (glob_desc_base),
        .glob_desc_limit   (glob_desc_limit),
        .glob_desc_2_limit (glob_desc_2_limit)
    );

    // Parameter 1 is the table base, parameter 2 the table limit.
    desc_table_reader u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .sel         (sel),
        .target      (target),
        .table_base  (glob_param_1),
        .table_limit (glob_param_2),
        .mem_rdata   (mem_rdata),
        .mem_rd      (mem_rd),
        .mem_addr    (mem_addr),
        .desc_set    (desc_set),
        .desc_2_set  (desc_2_set),
        .desc_value  (desc_value),
        .busy        (busy),
        .load_done   (load_done),
        .load_fault  (load_fault)
    );

    desc_limit_checker u_checker (
        .clk               (clk),
        .rst_n             (rst_n),
        .check             (check),
        .offset            (offset),
        .check_target      (check_target),
        .glob_descriptor   (glob_descriptor),
        .glob_descriptor_2 (glob_descriptor_2),
        .glob_desc_limit   (glob_desc_limit),
        .glob_desc_2_limit (glob_desc_2_limit),
        .check_valid       (check_valid),
        .check_fault       (check_fault)
    );

endmodule

//--- tb_desc_memory.sv
/*
 * Word memory model for the testbench.
 * Answers each read strobe one cycle later with the word at the byte
 * address. The testbench fills the words directly before any read.
 */
`timescale 1ns/10ps
`include "desc_defines.svh"

module tb_desc_memory #(
    parameter int DEPTH = 64
) (
    input  logic               clk,
    input  logic               rd,
    input  logic [`ADDR_W-1:0] addr,
    output logic [`ADDR_W-1:0] rdata
);

    // Word storage, indexed by byte address over four.
    logic [`ADDR_W-1:0] words [DEPTH];

    // Fixed one-cycle read latency.
    // Data holds between reads.
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= words[addr[$clog2(DEPTH)+1:2]];
        end
    end

endmodule

//--- tb_seg_desc_unit.sv
/*
 * Testbench for the segment descriptor unit.
 * Fills a table in the memory model with random descriptors, writes the
 * parameters, runs selector loads and offset checks, and compares every
 * result with a model built from the descriptor rules.
 */
`timescale 1ns/10ps
`include "desc_defines.svh"

module tb_seg_desc_unit;

    import desc_pkg::*;

    localparam int CYCLE_LIMIT = 400;

    logic clk;
    logic rst_n;
    logic [`PARAM_NUM-1:0] param_set;
    logic [`ADDR_W-1:0] param_value;
    logic load;
    sel_t sel;
    logic target;
    logic [`ADDR_W-1:0] mem_rdata;
    logic mem_rd;
    logic [`ADDR_W-1:0] mem_addr;
    logic check;
    logic [`ADDR_W-1:0] offset;
    logic check_target;
    logic busy;
    logic load_done;
    fault_e load_fault;
    logic check_valid;
    fault_e check_fault;
    logic [`ADDR_W-1:0] glob_param_1;
    logic [`ADDR_W-1:0] glob_param_2;
    logic [`ADDR_W-1:0] glob_param_3;
    logic [`ADDR_W-1:0] glob_param_4;
    logic [`ADDR_W-1:0] glob_param_5;
    logic [`DESC_W-1:0] glob_descriptor;
    logic [`DESC_W-1:0] glob_descriptor_2;
    logic [`ADDR_W-1:0] glob_desc_base;
    logic [`ADDR_W-1:0] glob_desc_limit;

    // Reference model state.
    logic [`ADDR_W-1:0] param_model [`PARAM_NUM];
    logic [`ADDR_W-1:0] mem_model [64];
    logic [`DESC_W-1:0] desc_1_model;
    logic [`DESC_W-1:0] desc_2_model;
    logic chk_tgt [$];
    logic [`ADDR_W-1:0] chk_off [$];
    int value_errors;
    int protocol_errors;
    int cycles;

    seg_desc_unit u_dut (.*);

    tb_desc_memory u_mem (
        .clk   (clk),
        .rd    (mem_rd),
        .addr  (mem_addr),
        .rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit well above the length of the sequence.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // Check result follows its request by exactly one cycle.
    a_check_latency: assert property (@(posedge clk) disable iff (!rst_n)
        check_valid == $past(check))
        else begin
            protocol_errors++;
            $display("check_valid out of step with check at %0t", $time);
        end

    // load_done is a single-cycle pulse.
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        load_done |=> !load_done)
        else begin
            protocol_errors++;
            $display("load_done held for more than one cycle at %0t", $time);
        end

    // Reads only happen inside a load, and a load ends with busy low.
    a_rd_in_load: assert property (@(posedge clk) disable iff (!rst_n) mem_rd |-> busy)
        else begin
            protocol_errors++;
            $display("mem_rd pulsed while busy was low at %0t", $time);
        end

    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n) load_done |-> !busy)
        else begin
            protocol_errors++;
            $display("busy still high with load_done at %0t", $time);
        end

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // Base is bits 63:56 then 39:16.
    function automatic logic [31:0] seg_base(input logic [63:0] d);
        seg_base = {d[63:56], d[39:16]};
    endfunction

    // G set means 4 KiB units, so the low 12 bits read as all ones.
    function automatic logic [31:0] scaled_limit(input logic [63:0] d);
        logic [31:0] raw;
        raw = {12'd0, d[51:48], d[15:0]};
        if (d[`DESC_BIT_G]) begin
            scaled_limit = (raw << 12) | 32'h0000_0FFF;
        end else begin
            scaled_limit = raw;
        end
    endfunction

    function automatic fault_e expected_fault(input logic [63:0] d, input logic [31:0] off);
        if (!d[`DESC_BIT_P]) begin
            expected_fault = FAULT_NOT_PRESENT;
        end else if (off > scaled_limit(d)) begin
            expected_fault = FAULT_LIMIT;
        end else begin
            expected_fault = FAULT_NONE;
        end
    endfunction

    // Random TI and RPL bits sit below the index and the reader must ignore them.
    function automatic sel_t sel_of(input int idx);
        sel_t s;
        s = sel_t'(idx) << `SEL_INDEX_LSB;
        sel_of = s | sel_t'($urandom_range(7));
    endfunction

    task automatic confirm_params();
        compare("glob_param_1", param_model[0], glob_param_1);
        compare("glob_param_2", param_model[1], glob_param_2);
        compare("glob_param_3", param_model[2], glob_param_3);
        compare("glob_param_4", param_model[3], glob_param_4);
        compare("glob_param_5", param_model[4], glob_param_5);
    endtask

    task automatic inspect_descriptors();
        compare("glob_descriptor", desc_1_model, glob_descriptor);
        compare("glob_descriptor_2", desc_2_model, glob_descriptor_2);
        compare("glob_desc_base", seg_base(desc_1_model), glob_desc_base);
        compare("glob_desc_limit", scaled_limit(desc_1_model), glob_desc_limit);
    endtask

    task automatic write_params(input logic [4:0] mask, input logic [31:0] value);
        @(negedge clk);
        param_set   = mask;
        param_value = value;
        for (int i = 0; i < `PARAM_NUM; i++) begin
            if (mask[i]) begin
                param_model[i] = value;
            end
        end
        @(negedge clk);
        param_set = '0;
        confirm_params();
    endtask

    // One selector load; retrigger holds load high a second cycle with
    // another entry and the other target, which must be ignored.
    task automatic load_entry(input int idx, input logic tgt, input bit retrigger);
        logic [31:0] entry_addr;
        logic [63:0] entry;
        logic [7:0]  rd_cycles;
        logic [31:0] rd_addr [$];
        bit          bound_bad;
        int          n;
        entry_addr = param_model[0] + 32'(idx) * 8;
        bound_bad  = (32'(idx) * 8 + 7) > param_model[1];
        entry      = {mem_model[entry_addr[7:2] + 1], mem_model[entry_addr[7:2]]};
        rd_cycles  = '0;
        n = 0;
        @(negedge clk);
        load   = 1'b1;
        sel    = sel_of(idx);
        target = tgt;
        do begin
            @(negedge clk);
            n++;
            if (retrigger && n == 1) begin
                sel    = sel_of(idx ^ 1);
                target = !tgt;
            end else begin
                load = 1'b0;
            end
            if (mem_rd) begin
                rd_cycles[n] = 1'b1;
                rd_addr.push_back(mem_addr);
            end
        end while (!load_done && n < 8);
        if (!load_done) begin
            value_errors++;
            $display("Load of table entry %0d never signalled load_done", idx);
        end
        compare("load_fault", bound_bad ? FAULT_SEL_LIMIT : FAULT_NONE, load_fault);
        compare("load_done cycle", bound_bad ? 2 : 4, n);
        compare("mem_rd cycles", bound_bad ? 8'h00 : 8'h06, rd_cycles);
        if (!bound_bad && rd_addr.size() == 2) begin
            compare("mem_addr low", entry_addr, rd_addr[0]);
            compare("mem_addr high", entry_addr + 4, rd_addr[1]);
        end
        if (!bound_bad && tgt) begin
            desc_2_model = entry;
        end else if (!bound_bad) begin
            desc_1_model = entry;
        end
        // The ignored load must leave no trace behind.
        if (retrigger) begin
            repeat (3) begin
                @(negedge clk);
                if (load_done || mem_rd) begin
                    protocol_errors++;
                    $display("A load raised while busy was taken at %0t", $time);
                end
            end
        end
        inspect_descriptors();
    endtask

    task automatic queue_check(input logic tgt, input logic [31:0] off);
        chk_tgt.push_back(tgt);
        chk_off.push_back(off);
    endtask

    // Back-to-back checks; each result is compared one cycle later.
    task automatic issue_checks();
        fault_e expected_q [$];
        int     n;
        n = chk_tgt.size();
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i > 0) begin
                compare("check_valid", 1, check_valid);
                compare("check_fault", expected_q.pop_front(), check_fault);
            end
            if (i < n) begin
                check        = 1'b1;
                check_target = chk_tgt[i];
                offset       = chk_off[i];
                expected_q.push_back(expected_fault(chk_tgt[i] ? desc_2_model : desc_1_model,
                                                    chk_off[i]));
            end else begin
                check = 1'b0;
            end
        end
        chk_tgt.delete();
        chk_off.delete();
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] lim;
        rst_n        = 1'b0;
        param_set    = '0;
        param_value  = '0;
        load         = 1'b0;
        sel          = '0;
        target       = 1'b0;
        check        = 1'b0;
        offset       = '0;
        check_target = 1'b0;
        desc_1_model = '0;
        desc_2_model = '0;
        for (int i = 0; i < `PARAM_NUM; i++) begin
            param_model[i] = '0;
        end
        word = $urandom(55567);

        // Word pair k holds one descriptor with G from k bit 0 and P from the inverse of k bit 1.
        for (int w = 0; w < 64; w++) begin
            word = $urandom;
            if (w[0]) begin
                word[`DESC_BIT_G - 32] = w[1];
                word[`DESC_BIT_P - 32] = !w[2];
            end
            mem_model[w]   = word;
            u_mem.words[w] = word;
        end

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        confirm_params();
        inspect_descriptors();
        compare("busy", 0, busy);
        compare("load_done", 0, load_done);
        compare("mem_rd", 0, mem_rd);
        compare("check_valid", 0, check_valid);
        compare("load_fault", FAULT_NONE, load_fault);
        compare("check_fault", FAULT_NONE, check_fault);

        // Both descriptors are still zero and neither is present.
        queue_check(1'b0, 32'h0);
        queue_check(1'b1, 32'h0);
        issue_checks();

        // Table at 0x40 with sixteen entries.
        write_params(5'b00100, 32'hA5A5_1234);
        write_params(5'b00001, 32'h0000_0040);
        write_params(5'b00010, 32'h0000_007F);
        write_params(5'b11000, 32'hC0DE_0F0F);

        // Entry 0 is present with G clear and entry 1 present with G set.
        load_entry(0, 1'b0, 1'b0);
        load_entry(1, 1'b1, 1'b0);
        lim = scaled_limit(desc_1_model);
        queue_check(1'b0, lim);
        queue_check(1'b0, lim + 1);
        lim = scaled_limit(desc_2_model);
        queue_check(1'b1, lim);
        queue_check(1'b1, lim + 1);
        issue_checks();

        // Entry 5 has G set; entry 2 is not present.
        load_entry(5, 1'b0, 1'b1);
        load_entry(2, 1'b1, 1'b0);
        lim = scaled_limit(desc_1_model);
        queue_check(1'b1, 32'h0);
        queue_check(1'b0, lim + 1);
        queue_check(1'b0, lim);
        queue_check(1'b1, lim);
        issue_checks();

        // Entry 15 ends exactly on the table limit and still loads.
        load_entry(15, 1'b0, 1'b0);

        // Entry 16 ends past the table limit.
        load_entry(16, 1'b0, 1'b0);
        repeat (2) @(negedge clk);

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
